// File: include/bch_params.svh
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Code and field constants for the BCH(15,7) syndrome unit
// Include wherever a width, polynomial or register address is needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef BCH_PARAMS_SVH
`define BCH_PARAMS_SVH

// GF(2^4) and code geometry
`define BCH_M 4 // Field element width
`define BCH_N 15 // Code length in bits

// Polynomials, bit k is the coefficient of x^k
`define BCH_FIELD_POLY 5'b10011 // x^4+x+1, primitive
`define BCH_MIN_POLY1 5'b10011 // Minimal poly of alpha
`define BCH_MIN_POLY3 5'b11111 // Minimal poly of alpha^3, x^4+x^3+x^2+x+1

// AXI4-Lite register map, byte addresses
`define BCH_ADDR_DATA 4'h0 // Received word, write only
`define BCH_ADDR_STATUS 4'h4 // busy / done / err
`define BCH_ADDR_SYN 4'h8 // s3 in [7:4], s1 in [3:0]

`endif

// File: design/bch_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared types of the BCH syndrome unit
// Import with bch_pkg::* in the module header
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bch_params.svh"

`default_nettype none

package bch_pkg;

	typedef logic [`BCH_M-1:0] gf_elem_t; // One GF(16) element
	typedef logic [`BCH_N-1:0] codeword_t; // Received word, MSB is r14
	typedef logic [3:0] bit_cnt_t; // Counts shifted bits 0..14

	// AXI4-Lite fields
	typedef logic [3:0] axil_addr_t; // Byte address inside the unit
	typedef logic [31:0] axil_data_t;
	typedef logic [1:0] axil_resp_t;

	// Sequencer states
	typedef enum logic [1:0] {
		idle, // Waiting for a DATA write
		shift, // Feeding bits to the remainder LFSRs
		latch // Remainders settled, capture syndromes
	} syn_state_t;

endpackage

`default_nettype wire

// File: design/bch_rem_lfsr.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Serial polynomial divider, one received bit per enabled cycle
// Holds r(x) mod f_j(x) after the last bit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bch_params.svh"

`default_nettype none

module bch_rem_lfsr
	import bch_pkg::*;
#(
	parameter int DEGREE = `BCH_M, // Degree of the minimal polynomial
	parameter logic [DEGREE:0] MIN_POLY = `BCH_MIN_POLY1 // Bit k is coeff of x^k
) (
	input wire logic clk,
	input wire logic arst_n,
	input wire logic ce, // Accept one more bit
	input wire logic start, // First bit of a new word
	input wire logic bit_in, // Highest coefficient first
	output gf_elem_t rem // Remainder b_j(x)
);

	logic [DEGREE-1:0] lfsr; // Running remainder
	logic [DEGREE-1:0] taps; // Feedback taps, x^DEGREE dropped
	logic fb; // Coefficient leaving the register

	// Remainder has to fit a field element
	if (DEGREE != `BCH_M) begin : g_degree_check
		$error("bch_rem_lfsr: DEGREE must equal the field width");
	end

	assign taps = MIN_POLY[DEGREE-1:0];
	assign fb = lfsr[DEGREE-1];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr <= '0;
		end else if (ce) begin
			if (start) begin
				lfsr <= {{(DEGREE-1){1'b0}}, bit_in}; // Restart from the new bit alone
			end else begin
				// Multiply by x, add the bit, reduce x^DEGREE by the taps
				lfsr <= {lfsr[DEGREE-2:0], bit_in} ^ (fb ? taps : '0);
			end
		end
	end

	assign rem = lfsr;

endmodule

`default_nettype wire

// File: design/bch_syn_expand.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Evaluates a remainder b_j(x) at alpha^j, giving syndrome S_j
// Purely combinational, constants built at elaboration
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bch_params.svh"

`default_nettype none

module bch_syn_expand
	import bch_pkg::*;
#(
	parameter int SYN = 1 // Power j of alpha
) (
	input gf_elem_t rem, // Remainder coefficients, bit i is x^i
	output gf_elem_t syn // b_j(alpha^j)
);

	localparam logic [`BCH_M:0] FIELD_POLY = `BCH_FIELD_POLY;

	// Table of alpha^(SYN*i), element i in bits [i*M +: M]
	function automatic logic [`BCH_M*`BCH_M-1:0] pow_table(input int j);
		logic [`BCH_M*`BCH_M-1:0] tbl;
		gf_elem_t a;
		tbl = '0;
		for (int i = 0; i < `BCH_M; i++) begin
			a = gf_elem_t'(1); // alpha^0
			// Repeated multiply by alpha, reduce with the field polynomial
			for (int k = 0; k < j * i; k++) begin
				a = {a[`BCH_M-2:0], 1'b0} ^ (a[`BCH_M-1] ? FIELD_POLY[`BCH_M-1:0] : '0);
			end
			tbl[i*`BCH_M +: `BCH_M] = a;
		end
		return tbl;
	endfunction

	localparam logic [`BCH_M*`BCH_M-1:0] POW_TBL = pow_table(SYN);

	// Sum of the powers picked by the remainder bits
	always_comb begin
		syn = '0;
		for (int i = 0; i < `BCH_M; i++) begin
			if (rem[i]) begin
				syn = syn ^ POW_TBL[i*`BCH_M +: `BCH_M];
			end
		end
	end

endmodule

`default_nettype wire

// File: design/bch_syn_ctrl.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequencer, shifts a stored word into the remainder LFSRs MSB first
// and captures S1, S3 and the error flag 16 cycles after the load
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bch_params.svh"

`default_nettype none

module bch_syn_ctrl
	import bch_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic start_req, // Accepted DATA write, this cycle
	input codeword_t word, // Word to load with start_req
	input gf_elem_t s1_in, // Live expander outputs
	input gf_elem_t s3_in,
	output logic ce, // LFSR enable
	output logic start, // Marks the first bit
	output logic bit_in, // Serial data to the LFSRs
	output logic busy,
	output logic done, // Result valid, cleared by the next load
	output logic err, // Some syndrome non-zero
	output gf_elem_t s1, // Captured syndromes
	output gf_elem_t s3
);

	syn_state_t state;
	bit_cnt_t cnt; // Bits already presented
	codeword_t shreg; // Word being shifted out

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= idle;
			cnt <= '0;
			done <= 1'b0;
			err <= 1'b0;
			s1 <= '0;
			s3 <= '0;
		end else begin
			case (state)
			idle: begin
				if (start_req) begin
					state <= shift;
					cnt <= '0;
					done <= 1'b0; // New word invalidates the old result
				end
			end
			shift: begin
				cnt <= cnt + 1'b1;
				if (cnt == bit_cnt_t'(`BCH_N - 1)) begin
					state <= latch; // Last bit goes in on this edge
				end
			end
			latch: begin
				s1 <= s1_in;
				s3 <= s3_in;
				err <= (s1_in != '0) || (s3_in != '0);
				done <= 1'b1;
				state <= idle;
			end
			default: state <= idle;
			endcase
		end
	end

	// Word store, MSB always at the top
	always_ff @(posedge clk) begin
		if (state == idle && start_req) begin
			shreg <= word;
		end else if (state == shift) begin
			shreg <= {shreg[`BCH_N-2:0], 1'b0};
		end
	end

	assign ce = (state == shift);
	assign start = ce && (cnt == '0); // Only with r14
	assign bit_in = shreg[`BCH_N-1];
	assign busy = (state != idle);

endmodule

`default_nettype wire

// File: design/bch_axil_regs.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite register slave of the syndrome unit
// DATA starts a run, STATUS and SYN report the result
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bch_params.svh"

`default_nettype none

module bch_axil_regs
	import bch_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	// Write address and data
	input wire logic awvalid,
	output logic awready,
	input axil_addr_t awaddr,
	input wire logic wvalid,
	output logic wready,
	input axil_data_t wdata,
	input wire logic [3:0] wstrb,
	// Write response
	output logic bvalid,
	input wire logic bready,
	output axil_resp_t bresp,
	// Read address
	input wire logic arvalid,
	output logic arready,
	input axil_addr_t araddr,
	// Read data
	output logic rvalid,
	input wire logic rready,
	output axil_data_t rdata,
	output axil_resp_t rresp,
	// Sequencer side
	output logic start_req,
	output codeword_t word,
	input wire logic busy,
	input wire logic done,
	input wire logic err,
	input gf_elem_t s1,
	input gf_elem_t s3
);

	localparam axil_resp_t RESP_OKAY = 2'b00;
	localparam axil_resp_t RESP_SLVERR = 2'b10;

	logic aw_hs; // Write address and data taken together
	logic ar_hs;
	logic wr_ok; // Legal DATA write
	axil_data_t rd_data; // Decoded read value
	axil_resp_t rd_resp;

	assign aw_hs = awready && awvalid && wvalid; // wready follows awready
	assign ar_hs = arready && arvalid;

	// DATA only, sequencer idle, both low byte lanes present
	assign wr_ok = (awaddr == `BCH_ADDR_DATA) && !busy && (&wstrb[1:0]);
	assign start_req = aw_hs && wr_ok;
	assign word = wdata[`BCH_N-1:0];

	// Write channel, one outstanding response
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			awready <= 1'b0;
			bvalid <= 1'b0;
		end else begin
			// One-cycle ready pulse once both halves are offered
			awready <= !awready && awvalid && wvalid && !bvalid;
			if (aw_hs) begin
				bvalid <= 1'b1;
			end else if (bready) begin
				bvalid <= 1'b0;
			end
		end
	end

	assign wready = awready;

	always_ff @(posedge clk) begin
		if (aw_hs) begin
			bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
		end
	end

	// Read decode, DATA is write only and reads zero
	always_comb begin
		rd_data = '0;
		rd_resp = RESP_OKAY;
		case (araddr)
		`BCH_ADDR_DATA: rd_data = '0;
		`BCH_ADDR_STATUS: rd_data = {29'd0, err, done, busy};
		`BCH_ADDR_SYN: rd_data = {24'd0, s3, s1};
		default: rd_resp = RESP_SLVERR; // Unmapped
		endcase
	end

	// Read channel
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
		end else begin
			arready <= !arready && arvalid && !rvalid; // Nothing pending
			if (ar_hs) begin
				rvalid <= 1'b1;
			end else if (rready) begin
				rvalid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ar_hs) begin
			rdata <= rd_data; // Held until rready
			rresp <= rd_resp;
		end
	end

endmodule

`default_nettype wire

// File: design/bch_syndrome_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// BCH(15,7) odd-syndrome unit with an AXI4-Lite slave port
// Write a word to DATA, poll STATUS, read S1/S3 from SYN
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bch_params.svh"

`default_nettype none

module bch_syndrome_top
	import bch_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic awvalid,
	output logic awready,
	input axil_addr_t awaddr,
	input wire logic wvalid,
	output logic wready,
	input axil_data_t wdata,
	input wire logic [3:0] wstrb,
	output logic bvalid,
	input wire logic bready,
	output axil_resp_t bresp,
	input wire logic arvalid,
	output logic arready,
	input axil_addr_t araddr,
	output logic rvalid,
	input wire logic rready,
	output axil_data_t rdata,
	output axil_resp_t rresp
);

	logic start_req; // regs to sequencer
	codeword_t word;
	logic busy; // sequencer to regs
	logic done;
	logic err;
	gf_elem_t s1;
	gf_elem_t s3;
	logic ce; // sequencer to both LFSRs
	logic start;
	logic bit_in;
	gf_elem_t rem1; // Remainders mod f1 and f3
	gf_elem_t rem3;
	gf_elem_t syn1; // Live syndromes
	gf_elem_t syn3;

	bch_axil_regs u_regs (
		.clk(clk), .arst_n(arst_n),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.start_req(start_req), .word(word),
		.busy(busy), .done(done), .err(err), .s1(s1), .s3(s3)
	);

	bch_syn_ctrl u_ctrl (
		.clk(clk), .arst_n(arst_n),
		.start_req(start_req), .word(word),
		.s1_in(syn1), .s3_in(syn3),
		.ce(ce), .start(start), .bit_in(bit_in),
		.busy(busy), .done(done), .err(err), .s1(s1), .s3(s3)
	);

	bch_rem_lfsr #(.DEGREE(`BCH_M), .MIN_POLY(`BCH_MIN_POLY1)) u_lfsr1 (
		.clk(clk), .arst_n(arst_n),
		.ce(ce), .start(start), .bit_in(bit_in), .rem(rem1)
	);

	bch_rem_lfsr #(.DEGREE(`BCH_M), .MIN_POLY(`BCH_MIN_POLY3)) u_lfsr3 (
		.clk(clk), .arst_n(arst_n),
		.ce(ce), .start(start), .bit_in(bit_in), .rem(rem3)
	);

	bch_syn_expand #(.SYN(1)) u_expand1 (.rem(rem1), .syn(syn1)); // S1 = b1(alpha)

	bch_syn_expand #(.SYN(3)) u_expand3 (.rem(rem3), .syn(syn3)); // S3 = b3(alpha^3)

endmodule

`default_nettype wire

// File: bench/bch_syndrome_checker.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Concurrent assertions on the syndrome unit, bound into its top level
// Covers reset state, AXI payload stability and done latency
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bch_params.svh"

`default_nettype none

module bch_syndrome_checker
	import bch_pkg::*;
(
	input wire logic clk,
	input wire logic arst_n,
	input wire logic awvalid,
	input wire logic awready,
	input axil_addr_t awaddr,
	input wire logic wvalid,
	input wire logic wready,
	input axil_data_t wdata,
	input wire logic bvalid,
	input wire logic bready,
	input axil_resp_t bresp,
	input wire logic arvalid,
	input wire logic arready,
	input axil_addr_t araddr,
	input wire logic rvalid,
	input wire logic rready,
	input axil_data_t rdata,
	input axil_resp_t rresp,
	input wire logic start_req, // Accepted DATA write
	input wire logic busy,
	input wire logic done,
	input gf_elem_t s1,
	input gf_elem_t s3
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_cnt = 0; // Summed into the testbench result

	// First edge after reset release still shows the reset values
	a_reset_state: assert property (@(posedge clk) $rose(arst_n) |->
		!awready && !wready && !arready && !bvalid && !rvalid && !busy && !done &&
		s1 == '0 && s3 == '0)
		else begin
			$error("outputs not idle when reset was released");
			fail_cnt++;
		end

	// Host side, valid holds its payload until ready
	a_aw_stable: assert property (@(posedge clk) disable iff (!arst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr))
		else begin
			$error("write address dropped or changed before awready");
			fail_cnt++;
		end

	a_w_stable: assert property (@(posedge clk) disable iff (!arst_n)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else begin
			$error("write data dropped or changed before wready");
			fail_cnt++;
		end

	a_ar_stable: assert property (@(posedge clk) disable iff (!arst_n)
		arvalid && !arready |=> arvalid && $stable(araddr))
		else begin
			$error("read address dropped or changed before arready");
			fail_cnt++;
		end

	// Slave side, responses held through back-pressure
	a_b_stable: assert property (@(posedge clk) disable iff (!arst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else begin
			$error("write response dropped or changed before bready");
			fail_cnt++;
		end

	a_r_stable: assert property (@(posedge clk) disable iff (!arst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else begin
			$error("read response dropped or changed before rready");
			fail_cnt++;
		end

	// done cleared by the load, set on edge T+16, seen at the sample after it
	a_done_clear: assert property (@(posedge clk) disable iff (!arst_n)
		start_req |=> !done)
		else begin
			$error("done still set after a new DATA write");
			fail_cnt++;
		end

	a_done_late: assert property (@(posedge clk) disable iff (!arst_n)
		$past(start_req, 17) |-> done)
		else begin
			$error("done not set 16 cycles after the DATA write");
			fail_cnt++;
		end

	a_done_early: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(done) |-> $past(start_req, 17))
		else begin
			$error("done rose at a wrong distance from the DATA write");
			fail_cnt++;
		end

endmodule

bind bch_syndrome_top bch_syndrome_checker u_checker (
	.clk(clk), .arst_n(arst_n),
	.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
	.wvalid(wvalid), .wready(wready), .wdata(wdata),
	.bvalid(bvalid), .bready(bready), .bresp(bresp),
	.arvalid(arvalid), .arready(arready), .araddr(araddr),
	.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
	.start_req(start_req), .busy(busy), .done(done), .s1(s1), .s3(s3)
);

`default_nettype wire

// File: bench/bch_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench of the BCH(15,7) syndrome unit
// Drives AXI4-Lite and compares S1/S3 with a Horner model in GF(16)
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`include "bch_params.svh"

`default_nettype none

module bch_tb
	import bch_pkg::*;
();
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT = 64; // Cycles allowed per channel wait
	localparam int MAX_POLLS = 40; // STATUS reads before giving up
	localparam axil_resp_t OKAY = 2'b00;
	localparam axil_resp_t SLVERR = 2'b10;
	localparam logic [8:0] GEN_POLY = 9'h1D1; // x^8+x^7+x^6+x^4+1

	logic clk = 1'b0;
	logic arst_n = 1'b0;
	logic awvalid = 1'b0;
	axil_addr_t awaddr = '0;
	logic wvalid = 1'b0;
	axil_data_t wdata = '0;
	logic [3:0] wstrb = '0;
	logic bready = 1'b0;
	logic arvalid = 1'b0;
	axil_addr_t araddr = '0;
	logic rready = 1'b0;
	logic awready;
	logic wready;
	logic bvalid;
	logic arready;
	logic rvalid;
	axil_resp_t bresp;
	axil_resp_t rresp;
	axil_data_t rdata;

	integer seed = 53949;
	int errors = 0;
	int checks = 0;
	int stall_max = 0; // Longest random bready/rready hold-off

	always #5 clk = ~clk;

	bch_syndrome_top dut0 (
		.clk(clk), .arst_n(arst_n),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
	);

	// x * a mod x^4+x+1
	function automatic gf_elem_t mul_alpha(input gf_elem_t a);
		logic [`BCH_M:0] poly;
		poly = `BCH_FIELD_POLY;
		return {a[`BCH_M-2:0], 1'b0} ^ (a[`BCH_M-1] ? poly[`BCH_M-1:0] : '0);
	endfunction

	function automatic gf_elem_t gf_mul(input gf_elem_t a, input gf_elem_t b);
		gf_elem_t p;
		gf_elem_t x;
		p = '0;
		x = a;
		for (int i = 0; i < `BCH_M; i++) begin
			if (b[i]) begin
				p = p ^ x;
			end
			x = mul_alpha(x);
		end
		return p;
	endfunction

	function automatic gf_elem_t alpha_pow(input int e);
		gf_elem_t a;
		a = gf_elem_t'(1);
		for (int k = 0; k < e; k++) begin
			a = mul_alpha(a);
		end
		return a;
	endfunction

	// Horner evaluation of r(alpha^j) starting at r14
	function automatic gf_elem_t eval_at(input codeword_t cw, input int j);
		gf_elem_t x;
		gf_elem_t s;
		x = alpha_pow(j);
		s = '0;
		for (int k = `BCH_N - 1; k >= 0; k--) begin
			s = gf_mul(s, x) ^ gf_elem_t'(cw[k]);
		end
		return s;
	endfunction

	// Codeword = m(x) * g(x) over GF(2)
	function automatic codeword_t encode(input logic [6:0] msg);
		codeword_t cw;
		cw = '0;
		for (int i = 0; i < 7; i++) begin
			if (msg[i]) cw = cw ^ (codeword_t'(GEN_POLY) << i);
		end
		return cw;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		assert (act === exp) else begin
			$display("Fail at %0t ns: %s expected 0x%0h got 0x%0h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic write_reg(input axil_addr_t addr, input axil_data_t data,
			output axil_resp_t resp);
		int n;
		resp = 2'b11;
		@(posedge clk);
		awvalid <= 1'b1;
		awaddr <= addr;
		wvalid <= 1'b1;
		wdata <= data;
		wstrb <= 4'hf;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!(awready && wready) && n < TIMEOUT); // Values from before this edge decide
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		if (!(awready && wready)) begin
			$display("Timeout at %0t ns: write address and data never accepted", $time);
			errors++;
		end else begin
			repeat ($unsigned($random(seed)) % (stall_max + 1)) @(posedge clk);
			bready <= 1'b1;
			n = 0;
			do begin
				@(posedge clk);
				n++;
			end while (!bvalid && n < TIMEOUT);
			bready <= 1'b0;
			if (bvalid) begin
				resp = bresp;
			end else begin
				$display("Timeout at %0t ns: write response never came", $time);
				errors++;
			end
		end
	endtask

	task automatic read_reg(input axil_addr_t addr, output axil_data_t data,
			output axil_resp_t resp);
		int n;
		data = '0;
		resp = 2'b11;
		@(posedge clk);
		arvalid <= 1'b1;
		araddr <= addr;
		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (!arready && n < TIMEOUT);
		arvalid <= 1'b0;
		if (!arready) begin
			$display("Timeout at %0t ns: read address never accepted", $time);
			errors++;
		end else begin
			repeat ($unsigned($random(seed)) % (stall_max + 1)) @(posedge clk);
			rready <= 1'b1;
			n = 0;
			do begin
				@(posedge clk);
				n++;
			end while (!rvalid && n < TIMEOUT);
			rready <= 1'b0;
			if (rvalid) begin
				data = rdata;
				resp = rresp;
			end else begin
				$display("Timeout at %0t ns: read data never came", $time);
				errors++;
			end
		end
	endtask

	// Poll STATUS until done
	task automatic wait_done();
		axil_data_t data;
		axil_resp_t resp;
		int n;
		n = 0;
		do begin
			read_reg(`BCH_ADDR_STATUS, data, resp);
			n++;
		end while (!data[1] && n < MAX_POLLS);
		if (!data[1]) begin
			$display("Timeout at %0t ns: done never set after a DATA write", $time);
			errors++;
		end
	endtask

	task automatic run_word(input codeword_t cw, input gf_elem_t exp_s1, input gf_elem_t exp_s3);
		axil_data_t data;
		axil_resp_t resp;
		logic exp_err;
		exp_err = (exp_s1 != '0) || (exp_s3 != '0);
		write_reg(`BCH_ADDR_DATA, axil_data_t'(cw), resp);
		check_val("bresp", OKAY, resp);
		wait_done();
		read_reg(`BCH_ADDR_SYN, data, resp);
		check_val("s1", exp_s1, data[3:0]);
		check_val("s3", exp_s3, data[7:4]);
		read_reg(`BCH_ADDR_STATUS, data, resp);
		check_val("status", {29'd0, exp_err, 2'b10}, data); // err, done, not busy
	endtask

	task automatic report_test(input int num, input string name, input int mark);
		$display("Test %0d %s: %0d errors", num, name, errors - mark);
	endtask

	initial begin
		axil_data_t data;
		axil_resp_t resp;
		codeword_t cw;
		logic [6:0] msg;
		int pos;
		int mark;
		int asrt_fails;

		repeat (4) @(posedge clk); // Reset held 4 cycles
		arst_n <= 1'b1;
		@(posedge clk);

		mark = errors;
		read_reg(`BCH_ADDR_STATUS, data, resp);
		check_val("status", 0, data);
		check_val("rresp", OKAY, resp);
		read_reg(`BCH_ADDR_SYN, data, resp);
		check_val("syn", 0, data);
		check_val("rresp", OKAY, resp);
		report_test(1, "reset state", mark);

		mark = errors;
		run_word('0, '0, '0);
		report_test(2, "all-zero word", mark);

		mark = errors;
		for (int t = 0; t < 20; t++) begin
			cw = codeword_t'($random(seed));
			run_word(cw, eval_at(cw, 1), eval_at(cw, 3));
		end
		report_test(3, "random words", mark);

		mark = errors;
		for (int t = 0; t < 6; t++) begin
			msg = 7'($random(seed));
			cw = encode(msg);
			run_word(cw, '0, '0);
			pos = $unsigned($random(seed)) % `BCH_N;
			run_word(cw ^ (codeword_t'(1) << pos), alpha_pow(pos), alpha_pow(3 * pos));
		end
		report_test(4, "codewords and single errors", mark);

		mark = errors;
		cw = codeword_t'($random(seed));
		write_reg(`BCH_ADDR_DATA, axil_data_t'(cw), resp);
		check_val("bresp", OKAY, resp);
		write_reg(`BCH_ADDR_DATA, axil_data_t'(~cw), resp); // Lands while busy
		check_val("bresp busy", SLVERR, resp);
		wait_done();
		read_reg(`BCH_ADDR_SYN, data, resp);
		check_val("s1", eval_at(cw, 1), data[3:0]);
		check_val("s3", eval_at(cw, 3), data[7:4]);
		read_reg(4'hC, data, resp);
		check_val("rresp unmapped", SLVERR, resp);
		check_val("rdata unmapped", 0, data);
		write_reg(`BCH_ADDR_SYN, '1, resp); // SYN is read-only
		check_val("bresp read-only", SLVERR, resp);
		read_reg(`BCH_ADDR_SYN, data, resp);
		check_val("s1 kept", eval_at(cw, 1), data[3:0]);
		check_val("s3 kept", eval_at(cw, 3), data[7:4]);
		report_test(5, "busy write, read-only write and unmapped read", mark);

		mark = errors;
		stall_max = 6;
		for (int t = 0; t < 8; t++) begin
			cw = codeword_t'($random(seed));
			run_word(cw, eval_at(cw, 1), eval_at(cw, 3));
		end
		stall_max = 0;
		report_test(6, "response back-pressure", mark);

		repeat (4) @(posedge clk);
		asrt_fails = dut0.u_checker.fail_cnt;
		$display("Checks %0d, errors %0d, assertion failures %0d", checks, errors, asrt_fails);
		if (errors == 0 && asrt_fails == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
+incdir+include
design/bch_pkg.sv
design/bch_rem_lfsr.sv
design/bch_syn_expand.sv
design/bch_syn_ctrl.sv
design/bch_axil_regs.sv
design/bch_syndrome_top.sv
bench/bch_syndrome_checker.sv
bench/bch_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the BCH syndrome testbench with Verilator.
# Exits non-zero when the build or run fails, or when the log reports failure.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
	-f compile.f --top-module bch_tb -Mdir obj_dir -o bch_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/bch_sim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
	exit 1
fi

exit 0
